// ==== include/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Word addressed CPU side
`define CACHE_ADDR_WIDTH 16
`define CACHE_WORD_WIDTH 32

`define CACHE_WORDS_PER_BLOCK 4
`define CACHE_OFFSET_WIDTH 2

`define CACHE_NUM_LINES 16
`define CACHE_INDEX_WIDTH 4

// Whatever is left of the address above index and offset
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_INDEX_WIDTH - `CACHE_OFFSET_WIDTH)

`define CACHE_BLOCK_WIDTH (`CACHE_WORDS_PER_BLOCK * `CACHE_WORD_WIDTH)

`endif

// ==== hw/cache_pkg.sv ====
`include "cache_params.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        PROCESS_REQ,
        ALLOCATE_CACHE,
        WRITE_BACK,
        FLUSH
    } ctrl_state_t;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_FLUSH
    } cpu_op_t;

    typedef struct packed {
        logic                          valid;
        cpu_op_t                       op;
        logic [`CACHE_ADDR_WIDTH-1:0]  addr;
        logic [`CACHE_WORD_WIDTH-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                          done;    // One cycle strobe
        logic [`CACHE_WORD_WIDTH-1:0]  rdata;
    } cpu_rsp_t;

    // Memory side works on whole blocks, so the address is tag and index only
    typedef struct packed {
        logic                                           valid;
        logic                                           wr;
        logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:0] addr;
        logic [`CACHE_BLOCK_WIDTH-1:0]                  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                          ack;
        logic [`CACHE_BLOCK_WIDTH-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic load_addr_en;
        logic cache_read;
        logic cache_write;
        logic allocate_cache;
        logic wr_bck_cache;
        logic zero_dirty;
    } store_ctrl_t;

endpackage

// ==== hw/cache_controller.sv ====
module cache_controller (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::cpu_req_t    cpu_req,
    input  logic                   hit,
    input  logic                   dirty,
    input  logic                   mem_ack,
    input  logic                   flush_done,
    output logic                   cpu_ready,
    output logic                   cpu_done,
    output cache_pkg::store_ctrl_t store_ctrl,
    output logic                   mem_valid,
    output logic                   mem_wr,
    output logic                   flush_start
);
    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        accept;
    logic        done_next;
    logic        start_next;

    // The CPU still holds its request during the done cycle, so it must not be taken again
    assign accept = cpu_req.valid & ~cpu_done;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= PROCESS_REQ;
            cpu_done    <= 1'b0;
            flush_start <= 1'b0;
        end else begin
            state       <= next_state;
            cpu_done    <= done_next;
            flush_start <= start_next;  // High in the first FLUSH cycle
        end
    end

    always_comb begin
        next_state = state;
        store_ctrl = '0;
        cpu_ready  = 1'b0;
        mem_valid  = 1'b0;
        mem_wr     = 1'b0;
        done_next  = 1'b0;
        start_next = 1'b0;

        case (state)
            PROCESS_REQ: begin
                cpu_ready = 1'b1;
                if (accept) begin
                    store_ctrl.load_addr_en = 1'b1;
                    if (cpu_req.op == OP_FLUSH) begin
                        start_next = 1'b1;
                        next_state = FLUSH;
                    end else if (hit) begin
                        done_next = 1'b1;
                        if (cpu_req.op == OP_WRITE) begin
                            store_ctrl.cache_write = 1'b1;
                        end else begin
                            store_ctrl.cache_read = 1'b1;
                        end
                    end else if (!dirty) begin
                        next_state = ALLOCATE_CACHE;
                    end else begin
                        // Victim block is captured on this edge for the write-back
                        store_ctrl.wr_bck_cache = 1'b1;
                        next_state = WRITE_BACK;
                    end
                end
            end

            ALLOCATE_CACHE: begin
                store_ctrl.allocate_cache = 1'b1;
                mem_valid = 1'b1;
                if (mem_ack) begin
                    next_state = PROCESS_REQ;  // Held request hits on the way back
                end
            end

            WRITE_BACK: begin
                mem_valid = 1'b1;
                mem_wr    = 1'b1;
                if (mem_ack) begin
                    store_ctrl.zero_dirty = 1'b1;
                    next_state = ALLOCATE_CACHE;
                end
            end

            FLUSH: begin
                if (flush_done) begin
                    done_next  = 1'b1;
                    next_state = PROCESS_REQ;
                end
            end

            default: begin
                next_state = PROCESS_REQ;
            end
        endcase
    end

endmodule

// ==== hw/cache_store.sv ====
`include "cache_params.svh"

module cache_store (
    input  logic                                           clk,
    input  logic                                           rst,
    input  cache_pkg::cpu_req_t                            cpu_req,
    input  cache_pkg::store_ctrl_t                         store_ctrl,
    input  logic [`CACHE_BLOCK_WIDTH-1:0]                  mem_rdata,
    input  logic                                           mem_ack,
    output logic                                           hit,
    output logic                                           dirty,
    output logic [`CACHE_WORD_WIDTH-1:0]                   rdata,
    output logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:0] evict_addr,
    output logic [`CACHE_BLOCK_WIDTH-1:0]                  evict_data,
    output logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:0] fill_addr,
    input  logic [`CACHE_INDEX_WIDTH-1:0]                  line_sel,
    output logic [`CACHE_TAG_WIDTH-1:0]                    line_tag,
    output logic                                           line_dirty,
    output logic [`CACHE_BLOCK_WIDTH-1:0]                  line_data,
    input  logic                                           line_invalidate
);
    logic [`CACHE_TAG_WIDTH-1:0]                    tag_mem  [`CACHE_NUM_LINES];
    logic [`CACHE_BLOCK_WIDTH-1:0]                  data_mem [`CACHE_NUM_LINES];
    logic [`CACHE_NUM_LINES-1:0]                    valid_bits;
    logic [`CACHE_NUM_LINES-1:0]                    dirty_bits;
    logic [`CACHE_TAG_WIDTH-1:0]                    req_tag;
    logic [`CACHE_INDEX_WIDTH-1:0]                  req_idx;
    logic [`CACHE_OFFSET_WIDTH-1:0]                 req_off;
    logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:0] lat_blk;
    logic [`CACHE_INDEX_WIDTH-1:0]                  lat_idx;
    logic                                           fill_now;

    assign {req_tag, req_idx, req_off} = cpu_req.addr;

    // Refill and write-back work on the address latched when the request was taken
    assign fill_addr = lat_blk;
    assign lat_idx   = lat_blk[`CACHE_INDEX_WIDTH-1:0];
    assign fill_now  = store_ctrl.allocate_cache & mem_ack;

    assign hit   = valid_bits[req_idx] & (tag_mem[req_idx] == req_tag);
    assign dirty = valid_bits[req_idx] & dirty_bits[req_idx];

    assign line_tag   = tag_mem[line_sel];
    assign line_data  = data_mem[line_sel];
    assign line_dirty = valid_bits[line_sel] & dirty_bits[line_sel];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (store_ctrl.cache_write) begin
                dirty_bits[req_idx] <= 1'b1;
            end
            if (store_ctrl.zero_dirty) begin
                dirty_bits[lat_idx] <= 1'b0;
            end
            if (fill_now) begin
                valid_bits[lat_idx] <= 1'b1;  // Fresh block is clean
                dirty_bits[lat_idx] <= 1'b0;
            end
            if (line_invalidate) begin
                valid_bits[line_sel] <= 1'b0;
                dirty_bits[line_sel] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_ctrl.cache_write) begin
            data_mem[req_idx][req_off*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH] <= cpu_req.wdata;
        end
        if (fill_now) begin
            data_mem[lat_idx] <= mem_rdata;
            tag_mem[lat_idx]  <= lat_blk[`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:`CACHE_INDEX_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (store_ctrl.load_addr_en) begin
            lat_blk <= cpu_req.addr[`CACHE_ADDR_WIDTH-1:`CACHE_OFFSET_WIDTH];
        end
        if (store_ctrl.cache_read) begin
            rdata <= data_mem[req_idx][req_off*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH];
        end
        // Old tag and block stay put for the whole write-back
        if (store_ctrl.wr_bck_cache) begin
            evict_addr <= {tag_mem[req_idx], req_idx};
            evict_data <= data_mem[req_idx];
        end
    end

endmodule

// ==== hw/flush_unit.sv ====
`include "cache_params.svh"

module flush_unit (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           flush_start,
    output logic                                           flush_done,
    output logic [`CACHE_INDEX_WIDTH-1:0]                  line_sel,
    input  logic [`CACHE_TAG_WIDTH-1:0]                    line_tag,
    input  logic                                           line_dirty,
    input  logic [`CACHE_BLOCK_WIDTH-1:0]                  line_data,
    output logic                                           line_invalidate,
    input  logic                                           ctrl_mem_valid,
    input  logic                                           ctrl_mem_wr,
    input  logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:0] evict_addr,
    input  logic [`CACHE_BLOCK_WIDTH-1:0]                  evict_data,
    input  logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:0] fill_addr,
    output cache_pkg::mem_req_t                            mem_req,
    input  logic                                           mem_ack
);
    logic                          busy;
    logic [`CACHE_INDEX_WIDTH-1:0] line_cnt;

    assign line_sel = line_cnt;

    // A clean line goes at once, a dirty one waits for its write-back ack
    assign line_invalidate = busy & (~line_dirty | mem_ack);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy       <= 1'b0;
            line_cnt   <= '0;
            flush_done <= 1'b0;
        end else begin
            flush_done <= 1'b0;
            if (flush_start) begin
                busy     <= 1'b1;
                line_cnt <= '0;
            end else if (line_invalidate) begin
                line_cnt <= line_cnt + 1'b1;  // Wraps to zero after the last line
                if (&line_cnt) begin
                    busy       <= 1'b0;
                    flush_done <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        if (busy) begin
            mem_req.valid = line_dirty;
            mem_req.wr    = 1'b1;
            mem_req.addr  = {line_tag, line_cnt};
            mem_req.wdata = line_data;
        end else begin
            mem_req.valid = ctrl_mem_valid;
            mem_req.wr    = ctrl_mem_wr;
            mem_req.addr  = ctrl_mem_wr ? evict_addr : fill_addr;
            mem_req.wdata = evict_data;
        end
    end

endmodule

// ==== hw/cache_top.sv ====
`include "cache_params.svh"

module cache_top (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req,
    output logic                cpu_ready,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);
    import cache_pkg::*;

    store_ctrl_t                                    store_ctrl;
    logic                                           hit;
    logic                                           dirty;
    logic                                           ctrl_mem_valid;
    logic                                           ctrl_mem_wr;
    logic                                           flush_start;
    logic                                           flush_done;
    logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:0] evict_addr;
    logic [`CACHE_BLOCK_WIDTH-1:0]                  evict_data;
    logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:0] fill_addr;
    logic [`CACHE_INDEX_WIDTH-1:0]                  line_sel;
    logic [`CACHE_TAG_WIDTH-1:0]                    line_tag;
    logic                                           line_dirty;
    logic [`CACHE_BLOCK_WIDTH-1:0]                  line_data;
    logic                                           line_invalidate;

    cache_controller u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .hit         (hit),
        .dirty       (dirty),
        .mem_ack     (mem_rsp.ack),
        .flush_done  (flush_done),
        .cpu_ready   (cpu_ready),
        .cpu_done    (cpu_rsp.done),
        .store_ctrl  (store_ctrl),
        .mem_valid   (ctrl_mem_valid),
        .mem_wr      (ctrl_mem_wr),
        .flush_start (flush_start)
    );

    cache_store u_store (
        .clk             (clk),
        .rst             (rst),
        .cpu_req         (cpu_req),
        .store_ctrl      (store_ctrl),
        .mem_rdata       (mem_rsp.rdata),
        .mem_ack         (mem_rsp.ack),
        .hit             (hit),
        .dirty           (dirty),
        .rdata           (cpu_rsp.rdata),
        .evict_addr      (evict_addr),
        .evict_data      (evict_data),
        .fill_addr       (fill_addr),
        .line_sel        (line_sel),
        .line_tag        (line_tag),
        .line_dirty      (line_dirty),
        .line_data       (line_data),
        .line_invalidate (line_invalidate)
    );

    // Flush unit also owns the memory port mux
    flush_unit u_flush (
        .clk             (clk),
        .rst             (rst),
        .flush_start     (flush_start),
        .flush_done      (flush_done),
        .line_sel        (line_sel),
        .line_tag        (line_tag),
        .line_dirty      (line_dirty),
        .line_data       (line_data),
        .line_invalidate (line_invalidate),
        .ctrl_mem_valid  (ctrl_mem_valid),
        .ctrl_mem_wr     (ctrl_mem_wr),
        .evict_addr      (evict_addr),
        .evict_data      (evict_data),
        .fill_addr       (fill_addr),
        .mem_req         (mem_req),
        .mem_ack         (mem_rsp.ack)
    );

endmodule

// ==== verification/cache_assertions.sv ====
module cache_assertions (
    input logic                   clk,
    input logic                   rst,
    input cache_pkg::ctrl_state_t state,
    input logic                   hit,
    input logic                   cpu_done,
    input logic                   mem_valid,
    input logic                   mem_wr,
    input logic                   mem_ack,
    input logic                   flush_start,
    input logic                   flush_done
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    int fail_count = 0;

    // The CPU holds its request, so the freshly filled line must match it
    refill_makes_request_hit: assert property (@(posedge clk) disable iff (!rst)
        state == ALLOCATE_CACHE && mem_ack |=> hit)
    else begin
        fail_count++;
        $error("Held request missed right after its refill");
    end

    // A memory request stays up with the same direction until it is acknowledged
    mem_valid_held: assert property (@(posedge clk) disable iff (!rst)
        mem_valid && !mem_ack |=> mem_valid && $stable(mem_wr))
    else begin
        fail_count++;
        $error("Memory request dropped or changed before its ack");
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (!rst)
        cpu_done |=> !cpu_done)
    else begin
        fail_count++;
        $error("cpu_done stayed high for more than one cycle");
    end

    flush_start_in_flush: assert property (@(posedge clk) disable iff (!rst)
        flush_start |-> state == FLUSH)
    else begin
        fail_count++;
        $error("flush_start seen outside the FLUSH state");
    end

    flush_ends_with_done: assert property (@(posedge clk) disable iff (!rst)
        state == FLUSH && flush_done |=> cpu_done && state == PROCESS_REQ)
    else begin
        fail_count++;
        $error("Flush completion not followed by done and PROCESS_REQ");
    end

endmodule

// ==== verification/cache_tb.sv ====
`include "cache_params.svh"

module cache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    localparam int blk_addr_w      = `CACHE_TAG_WIDTH + `CACHE_INDEX_WIDTH;
    localparam int block_w         = `CACHE_BLOCK_WIDTH;
    localparam int word_w          = `CACHE_WORD_WIDTH;
    localparam int mem_blocks      = 1 << blk_addr_w;
    localparam int num_reqs        = 12;
    localparam int num_flushes     = 1;
    localparam int done_limit      = 16 * 40;
    localparam int watchdog_cycles = 40 * (num_reqs + 16 * num_flushes) + 10;

    logic     clk;
    logic     rst;
    cpu_req_t cpu_req;
    logic     cpu_ready;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    logic [block_w-1:0]    mem [mem_blocks];
    logic [word_w-1:0]     ref_word [int];  // Every word the CPU has written, by word address
    logic                  log_wr [$];
    logic [blk_addr_w-1:0] log_addr [$];
    int                    mem_reads;
    int                    mem_writes;

    // Expected contents of each cache line under the direct-mapped rules
    logic [`CACHE_NUM_LINES-1:0] mdl_valid;
    logic [`CACHE_NUM_LINES-1:0] mdl_dirty;
    logic [`CACHE_TAG_WIDTH-1:0] mdl_tag [`CACHE_NUM_LINES];

    int     errors;
    int     checks;
    integer seed = 32'he4879112;

    cache_top UUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .cpu_rsp   (cpu_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    bind cache_controller cache_assertions chk (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .hit         (hit),
        .cpu_done    (cpu_done),
        .mem_valid   (mem_valid),
        .mem_wr      (mem_wr),
        .mem_ack     (mem_ack),
        .flush_start (flush_start),
        .flush_done  (flush_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [word_w-1:0] init_word(input logic [`CACHE_ADDR_WIDTH-1:0] addr);
        return {addr ^ 16'h5a3c, addr};
    endfunction

    function automatic logic [word_w-1:0] expected_word(input logic [`CACHE_ADDR_WIDTH-1:0] addr);
        if (ref_word.exists(int'(addr))) begin
            return ref_word[int'(addr)];
        end
        return init_word(addr);
    endfunction

    function automatic logic [block_w-1:0] expected_block(input logic [blk_addr_w-1:0] blk);
        logic [block_w-1:0] b;
        for (int i = 0; i < `CACHE_WORDS_PER_BLOCK; i++) begin
            b[i*word_w +: word_w] = expected_word({blk, i[`CACHE_OFFSET_WIDTH-1:0]});
        end
        return b;
    endfunction

    function automatic logic [word_w-1:0] read_mem_word(input logic [`CACHE_ADDR_WIDTH-1:0] addr);
        logic [block_w-1:0] b;
        b = mem[addr[`CACHE_ADDR_WIDTH-1:`CACHE_OFFSET_WIDTH]];
        return b[addr[`CACHE_OFFSET_WIDTH-1:0]*word_w +: word_w];
    endfunction

    function automatic logic [`CACHE_ADDR_WIDTH-1:0] make_addr(input int tag, input int idx,
                                                              input int off);
        return {tag[`CACHE_TAG_WIDTH-1:0], idx[`CACHE_INDEX_WIDTH-1:0],
                off[`CACHE_OFFSET_WIDTH-1:0]};
    endfunction

    // Main memory answers each block request after 1 to 4 cycles with one ack
    initial begin : memory_model
        logic [blk_addr_w-1:0] addr;
        logic [block_w-1:0]    wdata;
        logic                  wr;
        int                    delay;
        mem_rsp    = '0;
        mem_reads  = 0;
        mem_writes = 0;
        for (int blk = 0; blk < mem_blocks; blk++) begin
            for (int i = 0; i < `CACHE_WORDS_PER_BLOCK; i++) begin
                mem[blk][i*word_w +: word_w] =
                    init_word({blk[blk_addr_w-1:0], i[`CACHE_OFFSET_WIDTH-1:0]});
            end
        end
        forever begin
            @(negedge clk);
            if (rst && mem_req.valid) begin
                addr  = mem_req.addr;
                wr    = mem_req.wr;
                wdata = mem_req.wdata;
                delay = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay) @(posedge clk);
                mem_rsp.ack <= 1'b1;
                if (wr) begin
                    mem[addr] = wdata;
                    mem_writes++;
                end else begin
                    mem_rsp.rdata <= mem[addr];
                    mem_reads++;
                end
                log_wr.push_back(wr);
                log_addr.push_back(addr);
                @(posedge clk);
                mem_rsp.ack <= 1'b0;
            end
        end
    end

    task automatic check_value(input string name, input logic [block_w-1:0] got,
                               input logic [block_w-1:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // One CPU request with the memory traffic the line model predicts for it
    task automatic run_access(input cpu_op_t op, input logic [`CACHE_ADDR_WIDTH-1:0] addr,
                              input logic [word_w-1:0] wdata);
        logic [`CACHE_TAG_WIDTH-1:0]   tag;
        logic [`CACHE_INDEX_WIDTH-1:0] idx;
        logic [word_w-1:0]             exp_rdata;
        logic [word_w-1:0]             got_rdata;
        logic                          seen;
        int                            exp_reads;
        int                            exp_writes;
        int                            reads0;
        int                            writes0;
        tag        = addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
        idx        = addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
        exp_reads  = 0;
        exp_writes = 0;
        exp_rdata  = expected_word(addr);
        if (op == OP_FLUSH) begin
            exp_writes = $countones(mdl_valid & mdl_dirty);
            mdl_valid  = '0;
            mdl_dirty  = '0;
        end else begin
            if (!mdl_valid[idx] || mdl_tag[idx] != tag) begin
                exp_reads      = 1;
                exp_writes     = (mdl_valid[idx] && mdl_dirty[idx]) ? 1 : 0;
                mdl_valid[idx] = 1'b1;
                mdl_tag[idx]   = tag;
                mdl_dirty[idx] = 1'b0;
            end
            if (op == OP_WRITE) begin
                mdl_dirty[idx]       = 1'b1;
                ref_word[int'(addr)] = wdata;
            end
        end

        @(posedge clk);
        reads0  = mem_reads;
        writes0 = mem_writes;
        cpu_req <= '{valid: 1'b1, op: op, addr: addr, wdata: wdata};
        seen = 1'b0;
        for (int n = 0; n < done_limit && !seen; n++) begin
            @(negedge clk);
            seen = cpu_rsp.done;
        end
        got_rdata = cpu_rsp.rdata;  // Valid during the done cycle
        @(posedge clk);
        cpu_req <= '0;

        checks++;
        assert (seen) else begin
            errors++;
            $display("At %0t the cache gave no done within %0d cycles for address %h",
                     $time, done_limit, addr);
        end
        if (op == OP_READ) begin
            check_value("cpu_rsp.rdata", block_w'(got_rdata), block_w'(exp_rdata));
        end
        check_value("memory reads", block_w'(mem_reads - reads0), block_w'(exp_reads));
        check_value("memory writes", block_w'(mem_writes - writes0), block_w'(exp_writes));
    endtask

    task automatic verify_reset_state();
        @(negedge clk);
        check_value("cpu_ready", block_w'(cpu_ready), block_w'(1'b1));
        check_value("cpu_rsp.done", block_w'(cpu_rsp.done), '0);
        check_value("mem_req.valid", block_w'(mem_req.valid), '0);
        run_access(OP_READ, make_addr(3, 5, 1), '0);
    endtask

    task automatic write_then_read_hits();
        run_access(OP_WRITE, make_addr(3, 5, 2), 32'hcafe_0001);
        run_access(OP_READ, make_addr(3, 5, 2), '0);
        run_access(OP_READ, make_addr(3, 5, 1), '0);
    endtask

    task automatic evict_clean_line();
        run_access(OP_READ, make_addr(7, 9, 0), '0);
        run_access(OP_READ, make_addr(12, 9, 3), '0);  // Same index, line still clean
    endtask

    task automatic evict_dirty_line();
        logic [blk_addr_w-1:0] old_blk;
        logic [blk_addr_w-1:0] new_blk;
        int                    n0;
        old_blk = make_addr(3, 5, 0) >> `CACHE_OFFSET_WIDTH;
        new_blk = make_addr(20, 5, 0) >> `CACHE_OFFSET_WIDTH;
        run_access(OP_WRITE, make_addr(3, 5, 0), 32'h1234_abcd);
        n0 = log_wr.size();
        run_access(OP_READ, make_addr(20, 5, 2), '0);
        checks++;
        assert (log_wr.size() >= n0 + 2) else begin
            errors++;
            $display("Dirty eviction left %0d memory operations, a write and a read expected",
                     log_wr.size() - n0);
        end
        if (log_wr.size() >= n0 + 2) begin
            check_value("write-back mem_req.wr", block_w'(log_wr[n0]), block_w'(1'b1));
            check_value("write-back mem_req.addr", block_w'(log_addr[n0]), block_w'(old_blk));
            check_value("refill mem_req.wr", block_w'(log_wr[n0+1]), '0);
            check_value("refill mem_req.addr", block_w'(log_addr[n0+1]), block_w'(new_blk));
        end
        check_value("written-back block", mem[old_blk], expected_block(old_blk));
    endtask

    task automatic flush_and_reread();
        logic [`CACHE_ADDR_WIDTH-1:0] wa;
        run_access(OP_WRITE, make_addr(8, 2, 1), 32'h0bad_f00d);
        run_access(OP_WRITE, make_addr(9, 11, 3), 32'h7777_0042);
        run_access(OP_FLUSH, '0, '0);
        foreach (ref_word[a]) begin
            wa = `CACHE_ADDR_WIDTH'(a);
            check_value($sformatf("memory word %h", wa), block_w'(read_mem_word(wa)),
                        block_w'(ref_word[a]));
        end
        run_access(OP_READ, make_addr(20, 5, 2), '0);  // Was resident before the flush
    endtask

    initial begin
        rst       = 1'b0;
        cpu_req   = '0;
        errors    = 0;
        checks    = 0;
        mdl_valid = '0;
        mdl_dirty = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;

        verify_reset_state();
        write_then_read_hits();
        evict_clean_line();
        evict_dirty_line();
        flush_and_reread();

        repeat (2) @(posedge clk);
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, UUT.u_ctrl.chk.fail_count);
        if (errors == 0 && UUT.u_ctrl.chk.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
hw/cache_pkg.sv
hw/cache_controller.sv
hw/cache_store.sv
hw/flush_unit.sv
hw/cache_top.sv
verification/cache_assertions.sv
verification/cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_tb -f list.f -o sim_cache

./obj_dir/sim_cache +verilator+error+limit+100 | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"
